/* Bender.yml */
package:
  name: rv_core

sources:
  - target: rtl
    files:
      - common/rv_core_pkg.sv
      - rtl/rv_fetch.sv
      - rtl/rv_regfile.sv
      - execute/rv_int_exec.sv
      - csr/rv_csr_trap.sv
      - rtl/rv_commit.sv
      - rtl/rv_core.sv
  - target: dv
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv

/* all.f */
+incdir+dv
common/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
execute/rv_int_exec.sv
csr/rv_csr_trap.sv
rtl/rv_commit.sv
rtl/rv_core.sv
dv/rv_core_tb.sv

/* common/rv_core_pkg.sv */
// shared widths, opcodes, csr addresses and the instruction word views for the rv64 core
package rv_core_pkg;

    localparam int xlen = 64;  // register and data width
    localparam int ilen = 32;  // instruction width

    typedef logic [xlen-1:0] xword_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;

    // major opcodes, kept subset only
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add   = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3_slt   = 3'b010;
    localparam logic [2:0] f3_xor   = 3'b100;
    localparam logic [2:0] f3_or    = 3'b110;
    localparam logic [2:0] f3_and   = 3'b111;
    localparam logic [2:0] f3_beq   = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;
    localparam logic [2:0] f3_blt   = 3'b100;
    localparam logic [2:0] f3_bge   = 3'b101;
    localparam logic [2:0] f3_ld    = 3'b011;  // doubleword, ld and sd
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;
    localparam logic [2:0] f3_csrrc = 3'b011;
    localparam logic [2:0] f3_priv  = 3'b000;  // ecall, mret

    localparam logic [11:0] f12_ecall = 12'h000;
    localparam logic [11:0] f12_mret  = 12'h302;

    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mhartid  = 12'hF14;  // read only

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mstatus_mpp  = 11;  // two bits, 12:11

    localparam xword_t cause_ecall_m = 64'd11;  // ecall from machine mode

    // one instruction word seen through the formats it is decoded in
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;  // also csr address and funct12
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        u_view_t u;
    } rv_instr_u;

    localparam rv_instr_u nop_instr = 32'h0000_0013;  // addi x0,x0,0

endpackage

/* csr/rv_csr_trap.sv */
// machine csr file with csr read-modify-write, ecall entry and mret return
module rv_csr_trap #(
    parameter rv_core_pkg::xword_t hart_id = '0
) (
    input  logic                    clk_1hz,
    input  logic                    reset_n,
    input  rv_core_pkg::rv_instr_u  instr,
    input  rv_core_pkg::xword_t     instr_pc,
    input  logic                    instr_valid,
    input  rv_core_pkg::xword_t     rs1_data,
    output logic                    csr_wb_en,
    output rv_core_pkg::xword_t     csr_wb_data,
    output logic                    trap_taken,
    output rv_core_pkg::xword_t     trap_target
);

    logic                mie, mpie;
    logic [1:0]          mpp;
    rv_core_pkg::xword_t mtvec, mepc, mcause, mscratch;
    rv_core_pkg::xword_t mstatus_rd, csr_rdata, csr_wdata;
    logic                is_sys, is_csr, csr_we, is_ecall, is_mret;

    assign is_sys   = instr_valid && instr.i.opcode == rv_core_pkg::op_system;
    assign is_csr   = is_sys && (instr.i.funct3 == rv_core_pkg::f3_csrrw
                              || instr.i.funct3 == rv_core_pkg::f3_csrrs
                              || instr.i.funct3 == rv_core_pkg::f3_csrrc);
    assign is_ecall = is_sys && instr.i.funct3 == rv_core_pkg::f3_priv
                             && instr.i.imm12 == rv_core_pkg::f12_ecall;
    assign is_mret  = is_sys && instr.i.funct3 == rv_core_pkg::f3_priv
                             && instr.i.imm12 == rv_core_pkg::f12_mret;

    // set/clear with rs1 = x0 only reads
    assign csr_we = is_csr && (instr.i.funct3 == rv_core_pkg::f3_csrrw || instr.i.rs1 != 5'd0);

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[rv_core_pkg::mstatus_mie]       = mie;
        mstatus_rd[rv_core_pkg::mstatus_mpie]      = mpie;
        mstatus_rd[rv_core_pkg::mstatus_mpp +: 2]  = mpp;
        case (instr.i.imm12)  // csr address field
            rv_core_pkg::csr_mstatus:  csr_rdata = mstatus_rd;
            rv_core_pkg::csr_mtvec:    csr_rdata = mtvec;
            rv_core_pkg::csr_mscratch: csr_rdata = mscratch;
            rv_core_pkg::csr_mepc:     csr_rdata = mepc;
            rv_core_pkg::csr_mcause:   csr_rdata = mcause;
            rv_core_pkg::csr_mhartid:  csr_rdata = hart_id;
            default:                   csr_rdata = '0;
        endcase
        case (instr.i.funct3)
            rv_core_pkg::f3_csrrs: csr_wdata = csr_rdata | rs1_data;
            rv_core_pkg::f3_csrrc: csr_wdata = csr_rdata & ~rs1_data;
            default:               csr_wdata = rs1_data;  // csrrw
        endcase
    end

    assign csr_wb_en   = is_csr;
    assign csr_wb_data = csr_rdata;  // old value goes to rd
    assign trap_taken  = is_ecall || is_mret;
    assign trap_target = is_ecall ? {mtvec[63:2], 2'b00} : mepc;  // direct mode only

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mpp      <= 2'b00;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (is_ecall) begin
            mepc   <= instr_pc;
            mcause <= rv_core_pkg::cause_ecall_m;
            mpie   <= mie;
            mie    <= 1'b0;
            mpp    <= 2'b11;  // only machine mode exists
        end else if (is_mret) begin
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= 2'b11;
        end else if (csr_we) begin
            case (instr.i.imm12)
                rv_core_pkg::csr_mstatus: begin
                    mie  <= csr_wdata[rv_core_pkg::mstatus_mie];
                    mpie <= csr_wdata[rv_core_pkg::mstatus_mpie];
                    mpp  <= csr_wdata[rv_core_pkg::mstatus_mpp +: 2];
                end
                rv_core_pkg::csr_mtvec:    mtvec    <= csr_wdata;
                rv_core_pkg::csr_mscratch: mscratch <= csr_wdata;
                rv_core_pkg::csr_mepc:     mepc     <= csr_wdata;
                rv_core_pkg::csr_mcause:   mcause   <= csr_wdata;
                default: ;  // mhartid and unknown addresses ignore writes
            endcase
        end
    end

endmodule

/* dv/rv_core_programs.svh */
// program table for the core testbench, included inside rv_core_tb and walked by its run loop
`ifndef rv_core_programs_svh
`define rv_core_programs_svh

localparam int num_tests  = 5;
localparam int prog_words = 24;  // words per program, the rest of imem is zero

string test_name [num_tests] = '{"alu", "load_store", "branch_jump", "csr", "trap"};

// every program leaves its result in x10 and stores it to 0x100
rv_core_pkg::xword_t test_expect [num_tests] = '{
    64'hFFFF_FFFF_9234_6575,  // 1357 + 0x1028 + 0x12345000 + sign extended lui 0x80000
    64'hFFFF_FFFF_ABCD_E178,  // loaded 0x...ABCDE123 plus 0x55
    64'd79,                   // 1 + 2 + 4 + 16 + 8 + link 48
    64'd270,                  // 0 + 90 + 90 + 80 + 5 + 5
    64'h0000_0000_0000_199B   // mcause 11 + mepc 16 + mstatus 0x1880 + 0x100
};
int test_limit [num_tests] = '{60, 60, 60, 60, 60};  // cycles until the store must show

// extra data memory word that must hold after the run
bit                  test_mem_check [num_tests] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
rv_core_pkg::xword_t test_mem_addr  [num_tests] = '{64'h0, 64'h40, 64'h0, 64'h0, 64'h0};
rv_core_pkg::xword_t test_mem_value [num_tests] = '{
    64'h0, 64'hFFFF_FFFF_ABCD_E123, 64'h0, 64'h0, 64'h0
};

logic [31:0] test_code [num_tests][prog_words] = '{
    '{32'h06400093, 32'hFF900113, 32'h002081B3, 32'h40208233,  // x1=100 x2=-7 add sub
      32'h0F01C293, 32'h30026313, 32'h0FF37393, 32'h00112433,  // xori ori andi slt
      32'hFFA12493, 32'h123455B7, 32'h00001617, 32'h800006B7,  // slti lui auipc lui
      32'h00418533, 32'h00550533, 32'h00650533, 32'h00750533,  // sum into x10
      32'h00850533, 32'h00950533, 32'h00B50533, 32'h00C50533,
      32'h00D50533, 32'h10A03023, 32'h0000006F, 32'h00000000}, // sd result, spin
    '{32'h03800093, 32'hABCDE137, 32'h12310113, 32'h0020B423,  // sd x2 to 8(x1) = 0x40
      32'h0080B183, 32'h05500213, 32'h00418533, 32'h10A03023,  // ld back, add, store
      32'h0000006F, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    '{32'h00500093, 32'h00500113, 32'h00208463, 32'h3E850513,  // beq taken over +1000
      32'h00150513, 32'hFFD00193, 32'h0011C463, 32'h3E850513,  // blt taken over +1000
      32'h00250513, 32'h00209463, 32'h00450513, 32'h014002EF,  // bne falls through, jal x5
      32'h00850513, 32'h00550533, 32'h10A03023, 32'h0000006F,  // return point adds link
      32'h01050513, 32'h00028067, 32'h3E850513, 32'h00000000,  // subroutine, jalr x5
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    '{32'h05A00093, 32'h34009173, 32'h340021F3, 32'h00F00213,  // csrrw, csrrs x0 mscratch
      32'h340232F3, 32'h34002373, 32'hF14023F3, 32'hF1409073,  // csrrc, mhartid read/write
      32'hF1402473, 32'h00310533, 32'h00550533, 32'h00650533,
      32'h00750533, 32'h00850533, 32'h10A03023, 32'h0000006F,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    '{32'h00800093, 32'h3000A073, 32'h04000113, 32'h30511073,  // set mie, mtvec = 0x40
      32'h00000073, 32'h10050513, 32'h10A03023, 32'h0000006F,  // ecall at 0x10
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
      32'h342025F3, 32'h34102673, 32'h300026F3, 32'h00C58533,  // handler reads csrs
      32'h00D50533, 32'h00460613, 32'h34161073, 32'h30200073}  // mepc += 4, mret
};

`endif

/* dv/rv_core_tb.sv */
// testbench for rv_core, runs each table program from reset and checks its result store
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam rv_core_pkg::xword_t result_addr = 64'h100;
    localparam int reset_cycles = 10;

    logic                clk_1hz = 1'b0;
    logic                reset_n = 1'b0;
    rv_core_pkg::xword_t imem_addr;
    logic [31:0]         imem_data;
    rv_core_pkg::xword_t dmem_addr, dmem_wdata, dmem_rdata;
    logic                dmem_we;

    logic [31:0]         imem [64] = '{default: '0};  // word per pc/4
    rv_core_pkg::xword_t dmem [64] = '{default: '0};  // doubleword per addr/8

    int pass_count = 0;
    int fail_count = 0;
    bit test_bad;  // set by any check of the running test

    `include "rv_core_programs.svh"

    rv_core #(
        .reset_pc(64'h0),
        .hart_id (64'd5)
    ) dut_i (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we   (dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    always #2 clk_1hz = ~clk_1hz;  // 4 ns period

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[8:3]];

    always @(posedge clk_1hz) begin
        if (dmem_we)
            dmem[dmem_addr[8:3]] <= dmem_wdata;  // sd commits at the edge
    end

    // no store and pc at reset_pc while reset holds and one cycle after
    task automatic check_reset_state(input string phase);
        if (dmem_we !== 1'b0) begin
            $display("[FAIL] %0d ns: dmem_we is %b %s", $time, dmem_we, phase);
            test_bad = 1'b1;
        end
        if (imem_addr !== 64'h0) begin
            $display("[FAIL] %0d ns: imem_addr is %h %s, expected 0", $time, imem_addr, phase);
            test_bad = 1'b1;
        end
    endtask

    task automatic reset_and_load(input int t);
        @(posedge clk_1hz);
        #1;
        reset_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog_words) ? test_code[t][i] : 32'h0;  // zero words act as no-ops
            dmem[i] <= '0;
        end
        repeat (reset_cycles) begin
            @(negedge clk_1hz);
            check_reset_state("during reset");
            @(posedge clk_1hz);
            #1;
        end
        reset_n = 1'b1;
        @(negedge clk_1hz);  // first cycle out of reset
        check_reset_state("after reset");
    endtask

    // sample at the falling edge where the combinational store outputs are settled
    task automatic wait_result(input int limit, output bit seen, output rv_core_pkg::xword_t value);
        seen  = 1'b0;
        value = '0;
        for (int c = 0; c < limit && !seen; c++) begin
            @(negedge clk_1hz);
            if (dmem_we && dmem_addr == result_addr) begin
                seen  = 1'b1;
                value = dmem_wdata;
            end
        end
    endtask

    initial begin
        rv_core_pkg::xword_t got;
        bit                  seen;
        for (int t = 0; t < num_tests; t++) begin
            test_bad = 1'b0;
            reset_and_load(t);
            wait_result(test_limit[t], seen, got);
            if (!seen) begin
                $display("%s: no store to the result address arrived within %0d cycles",
                         test_name[t], test_limit[t]);
                test_bad = 1'b1;
            end else if (got !== test_expect[t]) begin
                $display("[FAIL] %0d ns: %s stored %h, expected %h",
                         $time, test_name[t], got, test_expect[t]);
                test_bad = 1'b1;
            end
            if (test_mem_check[t] && dmem[test_mem_addr[t][8:3]] !== test_mem_value[t]) begin
                $display("[FAIL] %0d ns: %s memory at %h holds %h, expected %h", $time,
                         test_name[t], test_mem_addr[t], dmem[test_mem_addr[t][8:3]],
                         test_mem_value[t]);
                test_bad = 1'b1;
            end
            if (test_bad) begin
                fail_count++;
                $display("test %s failed", test_name[t]);
            end else begin
                pass_count++;
                $display("test %s passed", test_name[t]);
            end
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* execute/rv_int_exec.sv */
// integer execute unit, alu, branch compare, jump targets and doubleword load/store
module rv_int_exec (
    input  rv_core_pkg::rv_instr_u  instr,
    input  rv_core_pkg::xword_t     instr_pc,
    input  logic                    instr_valid,
    input  rv_core_pkg::xword_t     rs1_data,
    input  rv_core_pkg::xword_t     rs2_data,
    output logic                    int_wb_en,
    output rv_core_pkg::xword_t     int_wb_data,
    output logic                    br_taken,
    output rv_core_pkg::xword_t     br_target,
    output rv_core_pkg::xword_t     dmem_addr,
    output rv_core_pkg::xword_t     dmem_wdata,
    output logic                    dmem_we,
    input  rv_core_pkg::xword_t     dmem_rdata
);

    rv_core_pkg::xword_t imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_core_pkg::xword_t alu_b;
    rv_core_pkg::xword_t link;

    // sign extended immediates, b and j rebuilt from the s and u views
    assign imm_i = {{52{instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_s = {{52{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{51{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                    instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {{32{instr.u.imm20[19]}}, instr.u.imm20, 12'b0};
    assign imm_j = {{43{instr.u.imm20[19]}}, instr.u.imm20[19], instr.u.imm20[7:0],
                    instr.u.imm20[8], instr.u.imm20[18:9], 1'b0};

    assign alu_b = (instr.r.opcode == rv_core_pkg::op_reg) ? rs2_data : imm_i;
    assign link  = instr_pc + 64'd4;

    always_comb begin
        int_wb_en   = 1'b0;
        int_wb_data = '0;
        br_taken    = 1'b0;
        br_target   = instr_pc + imm_b;
        dmem_addr   = rs1_data + imm_i;  // load address unless a store
        dmem_wdata  = rs2_data;
        dmem_we     = 1'b0;
        if (instr_valid) begin
            case (instr.r.opcode)
                rv_core_pkg::op_lui: begin
                    int_wb_en   = 1'b1;
                    int_wb_data = imm_u;
                end
                rv_core_pkg::op_auipc: begin
                    int_wb_en   = 1'b1;
                    int_wb_data = instr_pc + imm_u;
                end
                rv_core_pkg::op_imm, rv_core_pkg::op_reg: begin
                    int_wb_en = 1'b1;
                    case (instr.r.funct3)
                        rv_core_pkg::f3_add: begin
                            // funct7 bit 5 means sub, register form only
                            if (instr.r.opcode == rv_core_pkg::op_reg && instr.r.funct7[5])
                                int_wb_data = rs1_data - alu_b;
                            else
                                int_wb_data = rs1_data + alu_b;
                        end
                        rv_core_pkg::f3_slt:
                            int_wb_data = {63'd0, $signed(rs1_data) < $signed(alu_b)};
                        rv_core_pkg::f3_xor: int_wb_data = rs1_data ^ alu_b;
                        rv_core_pkg::f3_or:  int_wb_data = rs1_data | alu_b;
                        rv_core_pkg::f3_and: int_wb_data = rs1_data & alu_b;
                        default:             int_wb_en   = 1'b0;  // shifts, sltu dropped
                    endcase
                end
                rv_core_pkg::op_load: begin
                    int_wb_en   = (instr.i.funct3 == rv_core_pkg::f3_ld);
                    int_wb_data = dmem_rdata;  // same cycle read
                end
                rv_core_pkg::op_store: begin
                    dmem_addr = rs1_data + imm_s;
                    dmem_we   = (instr.s.funct3 == rv_core_pkg::f3_ld);
                end
                rv_core_pkg::op_jal: begin
                    int_wb_en   = 1'b1;
                    int_wb_data = link;
                    br_taken    = 1'b1;
                    br_target   = instr_pc + imm_j;
                end
                rv_core_pkg::op_jalr: begin
                    int_wb_en   = 1'b1;
                    int_wb_data = link;
                    br_taken    = 1'b1;
                    br_target   = (rs1_data + imm_i) & ~64'd1;
                end
                rv_core_pkg::op_branch: begin
                    case (instr.s.funct3)
                        rv_core_pkg::f3_beq: br_taken = (rs1_data == rs2_data);
                        rv_core_pkg::f3_bne: br_taken = (rs1_data != rs2_data);
                        rv_core_pkg::f3_blt: br_taken = $signed(rs1_data) < $signed(rs2_data);
                        rv_core_pkg::f3_bge: br_taken = $signed(rs1_data) >= $signed(rs2_data);
                        default:             br_taken = 1'b0;
                    endcase
                end
                default: ;  // system handled by the csr unit, rest are no-ops
            endcase
        end
    end

endmodule

/* rtl/rv_commit.sv */
// commit stage, merges both units into the register write and picks the pc redirect
module rv_commit (
    input  logic                   int_wb_en,
    input  rv_core_pkg::xword_t    int_wb_data,
    input  logic                   csr_wb_en,
    input  rv_core_pkg::xword_t    csr_wb_data,
    input  logic                   br_taken,
    input  rv_core_pkg::xword_t    br_target,
    input  logic                   trap_taken,
    input  rv_core_pkg::xword_t    trap_target,
    input  rv_core_pkg::reg_idx_t  rd_addr_in,
    output logic                   rd_we,
    output rv_core_pkg::reg_idx_t  rd_addr,
    output rv_core_pkg::xword_t    rd_data,
    output logic                   flush,
    output rv_core_pkg::xword_t    redirect_pc
);

    // the units decode disjoint opcodes, so at most one enable is set
    assign rd_we   = int_wb_en | csr_wb_en;
    assign rd_addr = rd_addr_in;
    assign rd_data = csr_wb_en ? csr_wb_data : int_wb_data;

    // trap or mret wins over a branch
    assign flush       = br_taken | trap_taken;
    assign redirect_pc = trap_taken ? trap_target : br_target;

endmodule

/* rtl/rv_core.sv */
// top of the two stage rv64 core, wires fetch, registers, both execute units and commit
module rv_core #(
    parameter rv_core_pkg::xword_t reset_pc = '0,
    parameter rv_core_pkg::xword_t hart_id  = '0
) (
    input  logic                          clk_1hz,
    input  logic                          reset_n,
    output rv_core_pkg::xword_t           imem_addr,
    input  logic [rv_core_pkg::ilen-1:0]  imem_data,
    output rv_core_pkg::xword_t           dmem_addr,
    output rv_core_pkg::xword_t           dmem_wdata,
    output logic                          dmem_we,
    input  rv_core_pkg::xword_t           dmem_rdata
);

    rv_core_pkg::rv_instr_u instr;
    rv_core_pkg::xword_t    instr_pc, rs1_data, rs2_data;
    rv_core_pkg::xword_t    int_wb_data, csr_wb_data, br_target, trap_target;
    rv_core_pkg::xword_t    rd_data, redirect_pc;
    rv_core_pkg::reg_idx_t  rd_addr;
    logic                   instr_valid, int_wb_en, csr_wb_en;
    logic                   br_taken, trap_taken, rd_we, flush;

    rv_fetch #(.reset_pc(reset_pc)) fetch_i (
        .clk_1hz, .reset_n, .flush, .redirect_pc, .imem_addr, .imem_data,
        .instr, .instr_pc, .instr_valid
    );

    rv_regfile regfile_i (
        .clk_1hz, .reset_n,
        .rs1_addr(instr.r.rs1), .rs2_addr(instr.r.rs2),
        .rs1_data, .rs2_data, .rd_we, .rd_addr, .rd_data
    );

    rv_int_exec int_exec_i (
        .instr, .instr_pc, .instr_valid, .rs1_data, .rs2_data,
        .int_wb_en, .int_wb_data, .br_taken, .br_target,
        .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
    );

    rv_csr_trap #(.hart_id(hart_id)) csr_trap_i (
        .clk_1hz, .reset_n, .instr, .instr_pc, .instr_valid, .rs1_data,
        .csr_wb_en, .csr_wb_data, .trap_taken, .trap_target
    );

    rv_commit commit_i (
        .int_wb_en, .int_wb_data, .csr_wb_en, .csr_wb_data,
        .br_taken, .br_target, .trap_taken, .trap_target,
        .rd_addr_in(instr.r.rd),  // rd sits at the same place in every view
        .rd_we, .rd_addr, .rd_data, .flush, .redirect_pc
    );

endmodule

/* rtl/rv_fetch.sv */
// fetch stage, holds pc and the instruction register and turns a flush into one bubble
module rv_fetch #(
    parameter rv_core_pkg::xword_t reset_pc = '0
) (
    input  logic                          clk_1hz,
    input  logic                          reset_n,
    input  logic                          flush,
    input  rv_core_pkg::xword_t           redirect_pc,
    output rv_core_pkg::xword_t           imem_addr,
    input  logic [rv_core_pkg::ilen-1:0]  imem_data,
    output rv_core_pkg::rv_instr_u        instr,
    output rv_core_pkg::xword_t           instr_pc,
    output logic                          instr_valid
);

    rv_core_pkg::xword_t pc;

    assign imem_addr = pc;  // memory answers in the same cycle

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc          <= reset_pc;
            instr       <= rv_core_pkg::nop_instr;
            instr_pc    <= '0;
            instr_valid <= 1'b0;
        end else if (flush) begin
            // drop the word already fetched, restart at the target
            pc          <= redirect_pc;
            instr       <= rv_core_pkg::nop_instr;
            instr_pc    <= pc;
            instr_valid <= 1'b0;
        end else begin
            pc          <= pc + 64'd4;
            instr       <= imem_data;
            instr_pc    <= pc;  // pc of the word now in instr
            instr_valid <= 1'b1;
        end
    end

endmodule

/* rtl/rv_regfile.sv */
// integer register file, two combinational reads and one write at the clock edge
module rv_regfile (
    input  logic                   clk_1hz,
    input  logic                   reset_n,
    input  rv_core_pkg::reg_idx_t  rs1_addr,
    input  rv_core_pkg::reg_idx_t  rs2_addr,
    output rv_core_pkg::xword_t    rs1_data,
    output rv_core_pkg::xword_t    rs2_data,
    input  logic                   rd_we,
    input  rv_core_pkg::reg_idx_t  rd_addr,
    input  rv_core_pkg::xword_t    rd_data
);

    rv_core_pkg::xword_t regs [32];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin  // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 stays zero since it is cleared on reset and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule
